// File: dsp_pkg.sv
// Shared types and constants for the sample-to-UART DSP chain.
// Samples are 16-bit unsigned. Segment patterns are active low, bit 6 is segment g.
`default_nettype none

package dsp_pkg;

    typedef logic [15:0] sample_t;
    typedef logic [15:0] coeff_t;
    typedef logic [7:0]  mag_t;

    // Sample with its strobe
    typedef struct packed {
        sample_t data;
        logic    valid;
    } sample_beat_t;

    localparam int FIR_TAPS = 16;

    // Symmetric triangle window
    localparam coeff_t FIR_COEFFS [0:FIR_TAPS-1] = '{
        16'h0100, 16'h0200, 16'h0300, 16'h0400,
        16'h0500, 16'h0600, 16'h0700, 16'h0800,
        16'h0800, 16'h0700, 16'h0600, 16'h0500,
        16'h0400, 16'h0300, 16'h0200, 16'h0100
    };

    localparam int BLOCK_LEN = 64;

    typedef enum logic {
        BLK_COLLECT,
        BLK_DRAIN
    } blk_state_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    localparam logic [6:0] SEG_BLANK = 7'b1111111;

    function automatic logic [6:0] hex_to_seg(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 7'b1000000;
            4'h1: return 7'b1111001;
            4'h2: return 7'b0100100;
            4'h3: return 7'b0110000;
            4'h4: return 7'b0011001;
            4'h5: return 7'b0010010;
            4'h6: return 7'b0000010;
            4'h7: return 7'b1111000;
            4'h8: return 7'b0000000;
            4'h9: return 7'b0010000;
            4'hA: return 7'b0001000;
            4'hB: return 7'b0000011;
            4'hC: return 7'b1000110;
            4'hD: return 7'b0100001;
            4'hE: return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: fir_filter.sv
// 16-tap FIR, fully parallel, one output per input strobe.
// Output is bits 31:16 of the 36-bit unsigned sum, which the coefficients keep below 2^31.
// The newest sample counts in the same cycle it arrives.
`default_nettype none

module fir_filter (
    input  logic                  clk,
    input  logic                  reset_n,
    input  dsp_pkg::sample_beat_t sample_in,
    output dsp_pkg::sample_beat_t filt
);
    import dsp_pkg::*;

    sample_t     delay_line [FIR_TAPS-1];
    sample_t     taps       [FIR_TAPS];
    logic [35:0] acc;

    // Window as it looks once the incoming sample is shifted in
    always_comb begin
        taps[0] = sample_in.data;
        for (int i = 1; i < FIR_TAPS; i++) begin
            taps[i] = delay_line[i-1];
        end
    end

    always_comb begin
        acc = '0;
        for (int i = 0; i < FIR_TAPS; i++) begin
            acc = acc + 36'(taps[i]) * 36'(FIR_COEFFS[i]);
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < FIR_TAPS - 1; i++) begin
                delay_line[i] <= '0;
            end
            filt <= '0;
        end else begin
            filt.valid <= sample_in.valid;
            if (sample_in.valid) begin
                for (int i = 0; i < FIR_TAPS - 1; i++) begin
                    delay_line[i] <= taps[i];
                end
                filt.data <= acc[31:16];
            end
        end
    end

    // No output without an input the cycle before
    a_no_spurious_valid: assert property (
        @(posedge clk) disable iff (!reset_n)
        !sample_in.valid |=> !filt.valid
    );

endmodule

`default_nettype wire

// File: block_magnitude.sv
// Collects BLOCK_LEN filtered samples, then emits one magnitude per UART byte.
// Magnitude is bits 32:25 of x*x + (x/2)*(x/2). BLOCK_LEN must be a power of two.
// Input samples arriving while draining are dropped.
`default_nettype none

module block_magnitude (
    input  logic                  clk,
    input  logic                  reset_n,
    input  dsp_pkg::sample_beat_t filt,
    input  logic                  tx_ready,
    output dsp_pkg::mag_t         mag,
    output logic                  mag_strobe
);
    import dsp_pkg::*;

    localparam int IDX_W = $clog2(BLOCK_LEN);

    sample_t          buffer [BLOCK_LEN];
    logic [IDX_W-1:0] idx;
    blk_state_t       state;
    sample_t          x;
    logic [32:0]      power;
    logic             last_idx;

    assign x        = buffer[idx];
    assign power    = 33'(x) * 33'(x) + 33'(x >> 1) * 33'(x >> 1);
    assign last_idx = (idx == IDX_W'(BLOCK_LEN - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < BLOCK_LEN; i++) begin
                buffer[i] <= '0;
            end
            idx        <= '0;
            state      <= BLK_COLLECT;
            mag        <= '0;
            mag_strobe <= 1'b0;
        end else begin
            mag_strobe <= 1'b0;
            case (state)
                BLK_COLLECT: begin
                    if (filt.valid) begin
                        buffer[idx] <= filt.data;
                        idx         <= idx + 1'b1;
                        if (last_idx) begin
                            state <= BLK_DRAIN;
                        end
                    end
                end
                BLK_DRAIN: begin
                    // tx_ready only drops the cycle after the strobe lands
                    if (tx_ready && !mag_strobe) begin
                        mag        <= power[32:25];
                        mag_strobe <= 1'b1;
                        idx        <= idx + 1'b1;
                        if (last_idx) begin
                            state <= BLK_COLLECT;
                        end
                    end
                end
                default: state <= BLK_COLLECT;
            endcase
        end
    end

    // Never hand a byte to a busy transmitter
    a_strobe_when_ready: assert property (
        @(posedge clk) disable iff (!reset_n)
        mag_strobe |-> tx_ready
    );

endmodule

`default_nettype wire

// File: uart_tx.sv
// 8N1 transmitter, LSB first, CLKS_PER_BIT clocks per bit.
// Start bit goes out the cycle after the strobe; tx_ready is low until stop ends.
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 4
) (
    input  logic          clk,
    input  logic          reset_n,
    input  dsp_pkg::mag_t mag,
    input  logic          mag_strobe,
    output logic          tx,
    output logic          tx_ready
);
    import dsp_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

    tx_state_t        state;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    mag_t             shift;
    logic             bit_done;

    assign bit_done = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= TX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;
            tx_ready <= 1'b1;
        end else begin
            if (state != TX_IDLE) begin
                clk_cnt <= bit_done ? '0 : clk_cnt + 1'b1;
            end
            case (state)
                TX_IDLE: begin
                    if (mag_strobe) begin
                        state    <= TX_START;
                        tx       <= 1'b0;
                        tx_ready <= 1'b0;
                        clk_cnt  <= '0;
                    end
                end
                TX_START: begin
                    if (bit_done) begin
                        state   <= TX_DATA;
                        tx      <= shift[0];
                        bit_idx <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_done) begin
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                            tx    <= 1'b1;
                        end else begin
                            tx      <= shift[0];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    if (bit_done) begin
                        state    <= TX_IDLE;
                        tx_ready <= 1'b1;
                    end
                end
            endcase
        end
    end

    // Byte register, next data bit always sits in bit 0
    always_ff @(posedge clk) begin
        if (state == TX_IDLE && mag_strobe) begin
            shift <= mag;
        end else if (bit_done && (state == TX_START || state == TX_DATA)) begin
            shift <= shift >> 1;
        end
    end

    // Upstream must wait for the frame to finish
    a_strobe_only_idle: assert property (
        @(posedge clk) disable iff (!reset_n)
        mag_strobe |-> state == TX_IDLE
    );

endmodule

`default_nettype wire

// File: seg7_scan.sv
// Four-digit multiplexed hex display, digit advances every clock.
// Digits 1:0 show mag, digits 3:2 show 0. Segments and digit selects are active low.
`default_nettype none

module seg7_scan (
    input  logic          clk,
    input  logic          reset_n,
    input  dsp_pkg::mag_t mag,
    output logic [6:0]    segments,
    output logic [3:0]    digit_sel
);
    import dsp_pkg::*;

    logic [1:0] scan;
    logic [3:0] nibble;

    always_comb begin
        case (scan)
            2'd0:    nibble = mag[3:0];
            2'd1:    nibble = mag[7:4];
            default: nibble = 4'h0;
        endcase
    end

    // Select and pattern registered in the same edge so they stay aligned
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            scan      <= '0;
            segments  <= SEG_BLANK;
            digit_sel <= 4'b1111;
        end else begin
            scan      <= scan + 1'b1;
            segments  <= hex_to_seg(nibble);
            digit_sel <= ~(4'b0001 << scan);
        end
    end

endmodule

`default_nettype wire

// File: dsp_top.sv
// Sample strobe in, FIR, 64-sample magnitude block, UART bytes out.
// One clock domain. Input samples are dropped while a block drains.
`default_nettype none

module dsp_top #(
    parameter int CLKS_PER_BIT = 4
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  dsp_pkg::sample_beat_t sample_in,
    output logic                  tx,
    output logic [6:0]            segments,
    output logic [3:0]            digit_sel
);
    import dsp_pkg::*;

    sample_beat_t filt;
    mag_t         mag;
    logic         mag_strobe;
    logic         tx_ready;

    fir_filter u_fir (
        .clk       (clk),
        .reset_n   (reset_n),
        .sample_in (sample_in),
        .filt      (filt)
    );

    block_magnitude u_block (
        .clk        (clk),
        .reset_n    (reset_n),
        .filt       (filt),
        .tx_ready   (tx_ready),
        .mag        (mag),
        .mag_strobe (mag_strobe)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart (
        .clk        (clk),
        .reset_n    (reset_n),
        .mag        (mag),
        .mag_strobe (mag_strobe),
        .tx         (tx),
        .tx_ready   (tx_ready)
    );

    seg7_scan u_seg (
        .clk       (clk),
        .reset_n   (reset_n),
        .mag       (mag),
        .segments  (segments),
        .digit_sel (digit_sel)
    );

endmodule

`default_nettype wire

// File: tb_dsp_top.sv
// Self-checking testbench for dsp_top with random samples from an xorshift source.
// Expected bytes come from an independent FIR and magnitude model.
// CLKS_PER_BIT must match the value given to the DUT.
`default_nettype none

module tb_dsp_top;
    import dsp_pkg::*;

    localparam int CLKS_PER_BIT = 4;
    localparam int FRAME        = 10 * CLKS_PER_BIT;
    localparam int HALF         = CLKS_PER_BIT / 2;
    // Active-low gfedcba patterns for 0..F
    localparam logic [6:0] SEG_TABLE [16] = '{
        7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
        7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
    };

    logic         clk = 1'b0;
    logic         reset_n;
    sample_beat_t sample_in;
    logic         tx;
    logic [6:0]   segments;
    logic [3:0]   digit_sel;

    logic [31:0]  rng;
    logic [15:0]  hist [16];
    logic [15:0]  block_vals [$];
    logic [7:0]   expected [$];
    logic [7:0]   last_byte = '0;
    logic [7:0]   shreg;
    logic [7:0]   want_byte;
    logic [6:0]   want_seg;
    logic         scanned = 1'b0;
    logic         busy = 1'b0;
    logic         prev_tx = 1'b1;
    int           pos = 0;
    int           rx_count = 0;
    int           mon_errors = 0;
    int           scan_errors = 0;
    int           seq_errors = 0;

    dsp_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uut (
        .clk       (clk),
        .reset_n   (reset_n),
        .sample_in (sample_in),
        .tx        (tx),
        .segments  (segments),
        .digit_sel (digit_sel)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        return v ^ (v << 5);
    endfunction

    // Top 8 of the 33-bit x*x + (x/2)*(x/2)
    function automatic logic [7:0] magnitude_of(input logic [15:0] x);
        longint p;
        p = longint'(x) * longint'(x) + longint'(x >> 1) * longint'(x >> 1);
        return 8'(p >> 25);
    endfunction

    // FIR history moves for every sample, dropped ones never reach a block
    task automatic send_block(input int n, input logic dropped);
        longint acc;
        int     gap;
        for (int s = 0; s < n; s++) begin
            rng = xorshift32(rng);
            sample_in.data  = rng[15:0];
            sample_in.valid = 1'b1;
            for (int i = 15; i > 0; i--) begin
                hist[i] = hist[i-1];
            end
            hist[0] = rng[15:0];
            acc = 0;
            for (int i = 0; i < 16; i++) begin
                // Triangle window rising by 0x100 up to 0x800 and back down
                acc += longint'(hist[i]) * longint'((i < 8 ? i + 1 : 16 - i) * 256);
            end
            if (!dropped) begin
                block_vals.push_back(16'(acc >> 16));
            end
            if (block_vals.size() == 64) begin
                foreach (block_vals[k]) begin
                    expected.push_back(magnitude_of(block_vals[k]));
                end
                block_vals.delete();
            end
            gap = int'(rng[29:28]);
            @(posedge clk);
            #1;
            sample_in.valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic wait_bytes(input int total, output logic late);
        int cycles;
        cycles = 0;
        while (rx_count < total && cycles < 100 * FRAME) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        late = rx_count < total;
        if (late) begin
            $display("Timeout after %0d cycles with %0d of %0d UART bytes received",
                     cycles, rx_count, total);
        end
    endtask

    // Quiet spell after a block where no further byte may show up
    task automatic check_count(input int total);
        repeat (3 * FRAME) begin
            @(posedge clk);
        end
        #1;
        assert (rx_count == total && expected.size() == 0) else begin
            seq_errors++;
            $display("MISMATCH at %0t: %0d UART bytes, expected %0d, %0d never sent",
                     $time, rx_count, total, expected.size());
        end
    endtask

    initial begin
        forever begin
            #2 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        scanned <= reset_n;
    end

    a_one_digit: assert property (
        @(posedge clk) disable iff (!reset_n)
        scanned |-> $onehot(~digit_sel)
    ) else begin
        scan_errors++;
        $display("MISMATCH at %0t: digit_sel %b is not a single active digit", $time, digit_sel);
    end

    // UART decoder plus reset and display checks, all on the falling edge
    always @(negedge clk) begin
        if (!scanned) begin
            assert (tx == 1'b1 && segments == 7'h7f && digit_sel == 4'hf) else begin
                mon_errors++;
                $display("MISMATCH at %0t: tx %b segments %b digit_sel %b before first scan",
                         $time, tx, segments, digit_sel);
            end
        end
        if (busy) begin
            pos++;
            assert (tx == prev_tx || pos % CLKS_PER_BIT == 0) else begin
                mon_errors++;
                $display("UART edge at %0t lies %0d cycles into a frame, off the bit grid",
                         $time, pos);
            end
            if (pos == HALF) begin
                assert (tx == 1'b0) else begin
                    mon_errors++;
                    $display("MISMATCH at %0t: start bit is high at its middle", $time);
                end
            end else if (pos == 9 * CLKS_PER_BIT + HALF) begin
                assert (tx == 1'b1) else begin
                    mon_errors++;
                    $display("MISMATCH at %0t: stop bit is low at its middle", $time);
                end
                if (expected.size() == 0) begin
                    mon_errors++;
                    $display("UART byte %h at %0t arrived with no byte expected", shreg, $time);
                end else begin
                    want_byte = expected.pop_front();
                    assert (shreg == want_byte) else begin
                        mon_errors++;
                        $display("MISMATCH at %0t: UART byte %0d is %h, expected %h",
                                 $time, rx_count, shreg, want_byte);
                    end
                end
                last_byte = shreg;
                rx_count++;
            end else if (pos % CLKS_PER_BIT == HALF) begin
                shreg = {tx, shreg[7:1]};
            end
            busy = (pos < FRAME - 1);
        end else if (reset_n && prev_tx && !tx) begin
            busy = 1'b1;
            pos  = 0;
        end
        prev_tx = tx;
        // Whole block out and line idle, so mag holds the last byte
        if (!busy && rx_count != 0 && rx_count % 64 == 0) begin
            case (digit_sel)
                4'b1110: want_seg = SEG_TABLE[last_byte[3:0]];
                4'b1101: want_seg = SEG_TABLE[last_byte[7:4]];
                default: want_seg = SEG_TABLE[0];
            endcase
            assert (segments == want_seg) else begin
                mon_errors++;
                $display("MISMATCH at %0t: digit_sel %b shows %b, expected %b",
                         $time, digit_sel, segments, want_seg);
            end
        end
    end

    initial begin
        logic late;
        int   total;
        reset_n   = 1'b0;
        sample_in = '0;
        rng       = 32'd91;
        late      = 1'b0;
        foreach (hist[i]) begin
            hist[i] = '0;
        end
        repeat (4) begin
            @(posedge clk);
        end
        #1;
        reset_n = 1'b1;
        send_block(64, 1'b0);
        // First byte out means block one is draining
        wait_bytes(1, late);
        if (!late) begin
            send_block(10, 1'b1);
            wait_bytes(64, late);
        end
        if (!late) begin
            check_count(64);
            send_block(64, 1'b0);
            wait_bytes(128, late);
        end
        if (!late) begin
            check_count(128);
        end
        total = mon_errors + scan_errors + seq_errors;
        $display("Errors: monitor %0d, digit select %0d, sequence %0d, timeout %0d",
                 mon_errors, scan_errors, seq_errors, late);
        if (late || total != 0) begin
            $display("Test failed");
        end else begin
            $display("Test completed successfully");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
dsp_pkg.sv
fir_filter.sv
block_magnitude.sv
uart_tx.sv
seg7_scan.sv
dsp_top.sv
tb_dsp_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run with Verilator, then fail if the log reports a failure
set -o pipefail
rm -f sim.log
verilator --binary --timing --assert --top-module tb_dsp_top -f src.f -o tb_sim \
    && ./obj_dir/tb_sim 2>&1 | tee sim.log \
    || { echo "Build or simulation run did not complete"; exit 1; }
grep -q "Test failed" sim.log && exit 1 || exit 0
